/* design/axi_lite_master.sv */
`timescale 1ns/1ps

module axi_lite_master import axi_pkg::*, req_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // queue side
    input  logic                  empty,
    output logic                  pop,
    input  req_op_e               head_op,
    input  req_src_e              head_src,
    input  logic [addr_width-1:0] head_addr,
    input  logic [data_width-1:0] head_wdata,
    input  logic [strb_width-1:0] head_wmask,
    // completion
    output logic                  done,
    output req_src_e              done_src,
    output req_op_e               done_op,
    output logic [data_width-1:0] done_rdata,
    // read address / data
    output logic [addr_width-1:0] araddr,
    output logic [2:0]            arprot,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic [data_width-1:0] rdata,
    input  logic                  rvalid,
    output logic                  rready,
    // write address / data / response
    output logic [addr_width-1:0] awaddr,
    output logic [2:0]            awprot,
    output logic                  awvalid,
    input  logic                  awready,
    output logic [data_width-1:0] wdata,
    output logic [strb_width-1:0] wstrb,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready
);

    typedef enum logic [2:0] {
        st_idle,
        st_raddr,
        st_rdata,
        st_wreq,  // aw and w outstanding
        st_wresp
    } state_e;

    state_e                state;
    logic                  aw_ok;    // aw accepted in this write
    logic                  w_ok;     // w accepted in this write
    logic                  ready_en; // rready/bready high once out of reset
    req_op_e               req_op;
    req_src_e              req_src;
    logic [addr_width-1:0] req_addr;
    logic [data_width-1:0] req_wdata;
    logic [strb_width-1:0] req_wmask;

    assign pop = state == st_idle && !empty;

    assign arvalid = state == st_raddr;
    assign awvalid = state == st_wreq && !aw_ok;
    assign wvalid  = state == st_wreq && !w_ok;
    assign rready  = ready_en;
    assign bready  = ready_en;

    assign araddr = req_addr;
    assign awaddr = req_addr;
    assign arprot = axi_prot_default;
    assign awprot = axi_prot_default;
    assign wdata  = req_wdata;
    assign wstrb  = req_wmask;

    assign done       = (state == st_rdata && rvalid && rready) ||
                        (state == st_wresp && bvalid && bready);
    assign done_src   = req_src;
    assign done_op    = req_op;
    assign done_rdata = rdata; // don't care on writes

    // latch the head at pop
    always_ff @(posedge clk) begin
        if (pop) begin
            req_op    <= head_op;
            req_src   <= head_src;
            req_addr  <= head_addr;
            req_wdata <= head_wdata;
            req_wmask <= head_wmask;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            aw_ok    <= 1'b0;
            w_ok     <= 1'b0;
            ready_en <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            case (state)
                st_idle:
                    if (pop) state <= (head_op == op_read) ? st_raddr : st_wreq;
                st_raddr:
                    if (arready) state <= st_rdata;
                st_rdata:
                    if (rvalid && rready) state <= st_idle;
                st_wreq: begin
                    if ((aw_ok || awready) && (w_ok || wready)) begin
                        state <= st_wresp;
                        aw_ok <= 1'b0;
                        w_ok  <= 1'b0;
                    end else begin
                        if (awready) aw_ok <= 1'b1;
                        if (wready) w_ok <= 1'b1;
                    end
                end
                st_wresp:
                    if (bvalid && bready) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* design/axi_mem.sv */
`timescale 1ns/1ps

module axi_mem import axi_pkg::*, req_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [addr_width-1:0] araddr,
    input  logic [2:0]            arprot,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [data_width-1:0] rdata,
    output logic                  rvalid,
    input  logic                  rready,
    input  logic [addr_width-1:0] awaddr,
    input  logic [2:0]            awprot,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [data_width-1:0] wdata,
    input  logic [strb_width-1:0] wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic                  bvalid,
    input  logic                  bready
);

    logic [data_width-1:0]      mem [mem_words];
    logic [mem_index_width-1:0] rd_index;
    logic [mem_index_width-1:0] wr_index;
    logic                       ar_hs;
    logic                       wr_hs;

    // word index from addr[9:2]
    assign rd_index = araddr[mem_index_width+1:2];
    assign wr_index = awaddr[mem_index_width+1:2];

    assign ar_hs = arvalid && arready;
    assign wr_hs = awvalid && awready && wvalid && wready; // aw and w taken together

    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
            rdata   <= '0;
        end else begin
            // single-cycle ready, one cycle after valid
            arready <= arvalid && !arready && !rvalid;
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !wready && !bvalid;

            if (ar_hs) begin
                rvalid <= 1'b1;
                rdata  <= mem[rd_index];
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end

            if (wr_hs) bvalid <= 1'b1;
            else if (bvalid && bready) bvalid <= 1'b0;
        end
    end

    // byte lanes selected by wstrb
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            for (int lane = 0; lane < strb_width; lane++) begin
                if (wstrb[lane]) mem[wr_index][lane*8 +: 8] <= wdata[lane*8 +: 8];
            end
        end
    end

endmodule

/* design/axi_pkg.sv */
package axi_pkg;

    // AXI4-Lite bus widths
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8; // one strobe per byte lane

    // every transaction is unprivileged, secure, data access
    localparam logic [2:0] axi_prot_default = 3'b000;

    // response encoding, only OKAY is ever returned
    localparam logic [1:0] resp_okay = 2'b00;

endpackage

/* design/mem_bridge_top.sv */
`timescale 1ns/1ps

module mem_bridge_top import axi_pkg::*, req_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // instruction port
    input  logic                  inst_ce,
    input  logic [addr_width-1:0] inst_addr,
    output logic [data_width-1:0] inst_rdata,
    output logic                  inst_rdata_valid,
    // data port
    input  logic                  data_ce,
    input  logic                  data_we,
    input  logic [addr_width-1:0] data_addr,
    input  logic [data_width-1:0] data_wdata,
    input  logic [strb_width-1:0] data_wmask,
    output logic [data_width-1:0] data_rdata,
    output logic                  data_rdata_valid,
    output logic                  data_write_finish
);

    // arbiter to queue
    logic                  full;
    logic                  push;
    req_op_e               push_op;
    req_src_e              push_src;
    logic [addr_width-1:0] push_addr;
    logic [data_width-1:0] push_wdata;
    logic [strb_width-1:0] push_wmask;

    // queue to master
    logic                  empty;
    logic                  pop;
    req_op_e               head_op;
    req_src_e              head_src;
    logic [addr_width-1:0] head_addr;
    logic [data_width-1:0] head_wdata;
    logic [strb_width-1:0] head_wmask;

    // completion back to the arbiter
    logic                  done;
    req_src_e              done_src;
    req_op_e               done_op;
    logic [data_width-1:0] done_rdata;

    // AXI4-Lite between master and memory
    logic [addr_width-1:0] araddr;
    logic [2:0]            arprot;
    logic                  arvalid;
    logic                  arready;
    logic [data_width-1:0] rdata;
    logic                  rvalid;
    logic                  rready;
    logic [addr_width-1:0] awaddr;
    logic [2:0]            awprot;
    logic                  awvalid;
    logic                  awready;
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    logic                  bvalid;
    logic                  bready;

    sram_arbiter sram_arbiter_inst (.*);

    req_fifo req_fifo_inst (.*);

    axi_lite_master axi_lite_master_inst (.*);

    axi_mem axi_mem_inst (.*);

endmodule

/* design/req_fifo.sv */
`timescale 1ns/1ps

module req_fifo import axi_pkg::*, req_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  req_op_e               push_op,
    input  req_src_e              push_src,
    input  logic [addr_width-1:0] push_addr,
    input  logic [data_width-1:0] push_wdata,
    input  logic [strb_width-1:0] push_wmask,
    input  logic                  pop,
    output req_op_e               head_op,
    output req_src_e              head_src,
    output logic [addr_width-1:0] head_addr,
    output logic [data_width-1:0] head_wdata,
    output logic [strb_width-1:0] head_wmask,
    output logic                  full,
    output logic                  empty
);

    req_op_e               op_q    [queue_depth];
    req_src_e              src_q   [queue_depth];
    logic [addr_width-1:0] addr_q  [queue_depth];
    logic [data_width-1:0] wdata_q [queue_depth];
    logic [strb_width-1:0] wmask_q [queue_depth];

    logic [queue_ptr_width-1:0] wr_ptr;
    logic [queue_ptr_width-1:0] rd_ptr;
    logic [queue_ptr_width:0]   count; // one extra bit to hold queue_depth

    assign full  = count == queue_depth[queue_ptr_width:0];
    assign empty = count == '0;

    // head is visible before the pop
    assign head_op    = op_q[rd_ptr];
    assign head_src   = src_q[rd_ptr];
    assign head_addr  = addr_q[rd_ptr];
    assign head_wdata = wdata_q[rd_ptr];
    assign head_wmask = wmask_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            op_q[wr_ptr]    <= push_op;
            src_q[wr_ptr]   <= push_src;
            addr_q[wr_ptr]  <= push_addr;
            wdata_q[wr_ptr] <= push_wdata;
            wmask_q[wr_ptr] <= push_wmask;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1; // wraps at queue_depth
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/req_pkg.sv */
package req_pkg;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } req_op_e;

    // which port issued the request
    typedef enum logic {
        src_inst = 1'b0,
        src_data = 1'b1
    } req_src_e;

    localparam int queue_depth     = 4;
    localparam int queue_ptr_width = $clog2(queue_depth);

    // on-chip word memory
    localparam int mem_words       = 256;
    localparam int mem_index_width = 8; // word index, addr[9:2]

endpackage

/* design/sram_arbiter.sv */
`timescale 1ns/1ps

module sram_arbiter import axi_pkg::*, req_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // instruction port
    input  logic                  inst_ce,
    input  logic [addr_width-1:0] inst_addr,
    output logic [data_width-1:0] inst_rdata,
    output logic                  inst_rdata_valid,
    // data port
    input  logic                  data_ce,
    input  logic                  data_we,
    input  logic [addr_width-1:0] data_addr,
    input  logic [data_width-1:0] data_wdata,
    input  logic [strb_width-1:0] data_wmask,
    output logic [data_width-1:0] data_rdata,
    output logic                  data_rdata_valid,
    output logic                  data_write_finish,
    // queue side
    input  logic                  full,
    output logic                  push,
    output req_op_e               push_op,
    output req_src_e              push_src,
    output logic [addr_width-1:0] push_addr,
    output logic [data_width-1:0] push_wdata,
    output logic [strb_width-1:0] push_wmask,
    // completion from the master
    input  logic                  done,
    input  req_src_e              done_src,
    input  req_op_e               done_op,
    input  logic [data_width-1:0] done_rdata
);

    logic inst_pend;
    logic data_pend;
    logic inst_new;
    logic data_new;
    logic sel_data;

    assign inst_new = inst_ce && !inst_pend; // held ce, not yet queued
    assign data_new = data_ce && !data_pend;
    assign sel_data = data_new;              // data wins a tie

    assign push       = !full && (inst_new || data_new);
    assign push_src   = sel_data ? src_data : src_inst;
    assign push_op    = (sel_data && data_we) ? op_write : op_read; // inst only reads
    assign push_addr  = sel_data ? data_addr : inst_addr;
    assign push_wdata = sel_data ? data_wdata : '0;
    assign push_wmask = sel_data ? data_wmask : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_pend <= 1'b0;
            data_pend <= 1'b0;
        end else begin
            // set on enqueue, cleared by the matching completion
            if (push && !sel_data) inst_pend <= 1'b1;
            else if (done && done_src == src_inst) inst_pend <= 1'b0;

            if (push && sel_data) data_pend <= 1'b1;
            else if (done && done_src == src_data) data_pend <= 1'b0;
        end
    end

    // completion routing, straight through
    assign inst_rdata        = done_rdata;
    assign data_rdata        = done_rdata;
    assign inst_rdata_valid  = done && done_src == src_inst;
    assign data_rdata_valid  = done && done_src == src_data && done_op == op_read;
    assign data_write_finish = done && done_src == src_data && done_op == op_write;

endmodule

/* mem_bridge_top.f */
design/axi_pkg.sv
design/req_pkg.sv
design/sram_arbiter.sv
design/req_fifo.sv
design/axi_lite_master.sv
design/axi_mem.sv
design/mem_bridge_top.sv
tests/mem_bridge_checker.sv
tests/mem_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the memory bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mem_bridge_top.f --top-module mem_bridge_tb \
    -Mdir obj_dir -o mem_bridge_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/mem_bridge_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

/* tests/mem_bridge_checker.sv */
`timescale 1ns/1ps

module mem_bridge_checker import axi_pkg::*, req_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_ce,
    input  logic [addr_width-1:0] inst_addr,
    input  logic [data_width-1:0] inst_rdata,
    input  logic                  inst_rdata_valid,
    input  logic                  data_ce,
    input  logic                  data_we,
    input  logic [addr_width-1:0] data_addr,
    input  logic [data_width-1:0] data_wdata,
    input  logic [strb_width-1:0] data_wmask,
    input  logic [data_width-1:0] data_rdata,
    input  logic                  data_rdata_valid,
    input  logic                  data_write_finish,
    output int                    mismatch_count,
    output int                    protocol_count
);

    logic [7:0] model [mem_words*strb_width]; // byte image of the memory
    logic       known [mem_words*strb_width]; // byte written at least once
    logic       inst_open;                    // request seen, no pulse yet
    logic       data_open;

    // word index from addr[9:2], the low two bits and everything above bit 9 ignored
    function automatic int byte_index(input logic [addr_width-1:0] addr, input int lane);
        return int'(addr[9:2]) * strb_width + lane;
    endfunction

    task automatic apply_write(input logic [addr_width-1:0] addr,
                               input logic [data_width-1:0] wdata,
                               input logic [strb_width-1:0] wmask);
        for (int lane = 0; lane < strb_width; lane++) begin
            if (wmask[lane]) begin
                model[byte_index(addr, lane)] = wdata[lane*8 +: 8];
                known[byte_index(addr, lane)] = 1'b1;
            end
        end
    endtask

    task automatic check_read(input string name,
                              input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] got);
        logic [data_width-1:0] expected;
        logic [data_width-1:0] care;
        for (int lane = 0; lane < strb_width; lane++) begin
            expected[lane*8 +: 8] = model[byte_index(addr, lane)];
            care[lane*8 +: 8]     = known[byte_index(addr, lane)] ? 8'hff : 8'h00;
        end
        if ((got & care) !== (expected & care)) begin
            $display("MISMATCH %s addr=%h got=%h expected=%h", name, addr, got, expected);
            mismatch_count++;
        end
    endtask

    initial begin
        for (int i = 0; i < mem_words * strb_width; i++) begin
            model[i] = 8'h00;
            known[i] = 1'b0;
        end
    end

    // outputs settle between edges, so everything is sampled on the falling edge
    always @(negedge clk) begin
        if (rst) begin
            inst_open      = 1'b0;
            data_open      = 1'b0;
            mismatch_count = 0;
            protocol_count = 0;
        end else begin
            if (inst_rdata_valid === 1'b1) begin
                if (!inst_open) begin
                    $display("inst_rdata_valid pulsed with no inst request outstanding");
                    protocol_count++;
                end else begin
                    check_read("inst_rdata", inst_addr, inst_rdata);
                end
                inst_open = 1'b0;
            end else if (inst_ce === 1'b1) begin
                inst_open = 1'b1;
            end

            if (data_write_finish === 1'b1 || data_rdata_valid === 1'b1) begin
                if (!data_open) begin
                    $display("data port completed with no data request outstanding");
                    protocol_count++;
                end else if (data_write_finish === 1'b1 && data_rdata_valid === 1'b1) begin
                    $display("data_write_finish and data_rdata_valid pulsed together");
                    protocol_count++;
                end else if (data_write_finish === 1'b1) begin
                    if (!data_we) begin
                        $display("data_write_finish pulsed for a read request");
                        protocol_count++;
                    end else begin
                        apply_write(data_addr, data_wdata, data_wmask);
                    end
                end else if (data_we) begin
                    $display("data_rdata_valid pulsed for a write request");
                    protocol_count++;
                end else begin
                    check_read("data_rdata", data_addr, data_rdata);
                end
                data_open = 1'b0;
            end else if (data_ce === 1'b1) begin
                data_open = 1'b1;
            end
        end
    end

endmodule

/* tests/mem_bridge_tb.sv */
`timescale 1ns/1ps

module mem_bridge_tb import axi_pkg::*, req_pkg::*; ();

    localparam int timeout_cycles = 200;
    localparam int stim_words     = 6 * 64; // six columns per request line

    logic                  clk;
    logic                  rst;
    logic                  inst_ce;
    logic [addr_width-1:0] inst_addr;
    logic [data_width-1:0] inst_rdata;
    logic                  inst_rdata_valid;
    logic                  data_ce;
    logic                  data_we;
    logic [addr_width-1:0] data_addr;
    logic [data_width-1:0] data_wdata;
    logic [strb_width-1:0] data_wmask;
    logic [data_width-1:0] data_rdata;
    logic                  data_rdata_valid;
    logic                  data_write_finish;

    logic [31:0] stim [stim_words];
    int          timeout_count;
    int          request_count;
    int          stim_errors;
    int          mismatch_count;
    int          protocol_count;

    mem_bridge_top mem_bridge_top_inst (.*);

    mem_bridge_checker compare_inst (
        .clk               (clk),
        .rst               (rst),
        .inst_ce           (inst_ce),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .inst_rdata_valid  (inst_rdata_valid),
        .data_ce           (data_ce),
        .data_we           (data_we),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .data_wmask        (data_wmask),
        .data_rdata        (data_rdata),
        .data_rdata_valid  (data_rdata_valid),
        .data_write_finish (data_write_finish),
        .mismatch_count    (mismatch_count),
        .protocol_count    (protocol_count)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk; // 4 ns period

    task automatic fetch_inst(input logic [addr_width-1:0] addr);
        int   cycles;
        logic seen;
        @(posedge clk);
        inst_ce   <= 1'b1;
        inst_addr <= addr;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
            seen = inst_rdata_valid === 1'b1;
        end
        if (!seen) begin
            $display("inst port did not complete the read of %h within %0d cycles",
                     addr, timeout_cycles);
            timeout_count++;
        end
        @(posedge clk);
        inst_ce <= 1'b0; // held until the edge that ends the pulse
    endtask

    task automatic access_data(input logic                  we,
                               input logic [addr_width-1:0] addr,
                               input logic [data_width-1:0] wdata,
                               input logic [strb_width-1:0] wmask);
        int   cycles;
        logic seen;
        @(posedge clk);
        data_ce    <= 1'b1;
        data_we    <= we;
        data_addr  <= addr;
        data_wdata <= wdata;
        data_wmask <= wmask;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
            seen = we ? (data_write_finish === 1'b1) : (data_rdata_valid === 1'b1);
        end
        if (!seen) begin
            $display("data port did not complete the %s of %h within %0d cycles",
                     we ? "write" : "read", addr, timeout_cycles);
            timeout_count++;
        end
        @(posedge clk);
        data_ce <= 1'b0;
    endtask

    // one request line starting at stim[base]
    task automatic issue(input int base);
        request_count++;
        if (stim[base] == 32'h0) begin
            fetch_inst(stim[base + 2]);
        end else begin
            access_data(stim[base + 1][0], stim[base + 2], stim[base + 3],
                        stim[base + 4][strb_width-1:0]);
        end
    endtask

    initial begin
        int idx;
        int gap;
        void'($urandom(4745));
        rst           <= 1'b1;
        inst_ce       <= 1'b0;
        inst_addr     <= '0;
        data_ce       <= 1'b0;
        data_we       <= 1'b0;
        data_addr     <= '0;
        data_wdata    <= '0;
        data_wmask    <= '0;
        timeout_count = 0;
        request_count = 0;
        stim_errors   = 0;
        $readmemh("tests/mem_bridge_testdata.txt", stim);

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        idx = 0;
        while (idx + 12 <= stim_words && stim[idx] != 32'hf && timeout_count == 0) begin
            if (stim[idx + 5] == 32'hff) begin
                // both ports raised on the same edge
                fork
                    issue(idx);
                    issue(idx + 6);
                join
                gap = stim[idx + 11];
                idx += 12;
            end else begin
                issue(idx);
                gap = stim[idx + 5];
                idx += 6;
            end
            gap += $urandom % 3; // random extra idle cycles
            repeat (gap) @(posedge clk);
        end

        if (request_count == 0) begin
            $display("no requests were read from the data file");
            stim_errors++;
        end
        repeat (2) @(posedge clk);
        $display("errors: mismatch=%0d protocol=%0d timeout=%0d stimulus=%0d",
                 mismatch_count, protocol_count, timeout_count, stim_errors);
        if (mismatch_count + protocol_count + timeout_count + stim_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tests/mem_bridge_testdata.txt */
// port (0 inst, 1 data)  op (0 read, 1 write)  address  write data  mask  idle gap
// gap ff raises this line together with the next one, port f ends the list
1 1 00000000 11223344 f 0
1 1 00000004 55667788 f 1
1 1 00000010 a5a5a5a5 f 0
1 0 00000000 00000000 0 0
1 0 00000004 00000000 0 2
1 1 00000010 000000cc 1 0
1 1 00000010 dd000000 8 0
1 0 00000010 00000000 0 1
0 0 00000004 00000000 0 0
0 0 00000000 00000000 0 ff
1 0 00000010 00000000 0 0
1 1 00000404 cafef00d f 0
0 0 80000006 00000000 0 0
1 0 00000007 00000000 0 0
1 1 00000020 12345678 f 0
1 0 00000020 00000000 0 0
0 0 00000010 00000000 0 ff
1 1 00000020 ffff0000 c 0
1 0 00000420 00000000 0 0
f 0 00000000 00000000 0 0
